// ==== hdl/dtm_pkg.sv ====
// shared definitions for the jtag debug transport
//   dtm widths, idcode and instruction codes
//   sticky dmi status codes
//   dmi target size and busy time
//   tap state encoding
//   dmi request and response structs
//   dbus / dtmcontrol views of the data register

package dtm_pkg;

    localparam int DTM_ABITS = 7;                    // dmi address width
    localparam int DTM_IRLEN = 5;
    localparam int DTM_DRLEN = DTM_ABITS + 34;       // addr + data + op
    localparam logic [31:0] DTM_IDCODE = 32'h10e31913;

    // instruction codes
    localparam logic [DTM_IRLEN-1:0] IR_IDCODE     = 5'h01;
    localparam logic [DTM_IRLEN-1:0] IR_DTMCONTROL = 5'h10;
    localparam logic [DTM_IRLEN-1:0] IR_DBUS       = 5'h11;
    localparam logic [DTM_IRLEN-1:0] IR_BYPASS     = 5'h1f;

    localparam logic [1:0] DMISTAT_SUCCESS = 2'h0;
    localparam logic [1:0] DMISTAT_FAILED  = 2'h2;
    localparam logic [1:0] DMISTAT_BUSY    = 2'h3;

    localparam int DMI_REG_COUNT   = 16;             // addresses at or above are errors
    localparam int DMI_BUSY_CYCLES = 64;

    typedef enum logic [3:0] {
        TEST_LOGIC_RESET = 4'd0,
        RUN_TEST_IDLE    = 4'd1,
        SELECT_DR_SCAN   = 4'd2,
        CAPTURE_DR       = 4'd3,
        SHIFT_DR         = 4'd4,
        EXIT1_DR         = 4'd5,
        PAUSE_DR         = 4'd6,
        EXIT2_DR         = 4'd7,
        UPDATE_DR        = 4'd8,
        SELECT_IR_SCAN   = 4'd9,
        CAPTURE_IR       = 4'd10,
        SHIFT_IR         = 4'd11,
        EXIT1_IR         = 4'd12,
        PAUSE_IR         = 4'd13,
        EXIT2_IR         = 4'd14,
        UPDATE_IR        = 4'd15
    } tap_state_e;

    typedef struct packed {
        logic                 valid;
        logic                 write;
        logic [DTM_ABITS-1:0] addr;
        logic [31:0]          data;
    } dmi_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic        busy;
        logic        error;
    } dmi_resp_t;

    // dbus scan layout with op in the low bits
    typedef struct packed {
        logic [DTM_ABITS-1:0] addr;
        logic [31:0]          data;
        logic [1:0]           op;
    } dtm_dbus_t;

    // dtmcontrol layout padded with zeros above bit 17
    typedef struct packed {
        logic [DTM_DRLEN-19:0] pad;
        logic                  dmihardreset;      // bit 17
        logic                  dmireset;          // bit 16
        logic [3:0]            rsvd;
        logic [1:0]            dmistat;
        logic [5:0]            abits;
        logic [3:0]            version;
    } dtm_ctrl_t;

    // one shift register read per selected instruction
    typedef union packed {
        dtm_dbus_t dbus;
        dtm_ctrl_t ctrl;
    } dtm_dr_u;

endpackage

// ==== hdl/jtag_dtm.sv ====
// jtag debug transport module
//   16-state tap controller on tck/tms
//   instruction register, updated on the falling edge
//   idcode, dtmcontrol, dbus and bypass data registers
//   sticky dmi status, dmireset and dmihardreset
//   one-cycle dmi request on dbus update

`timescale 1ns/10ps

module jtag_dtm (
    input  logic               i_tck,
    input  logic               i_trst,
    input  logic               i_tms,
    input  logic               i_tdi,
    input  dtm_pkg::dmi_resp_t i_dmi_resp,
    output logic               o_tdo,
    output dtm_pkg::dmi_req_t  o_dmi_req,
    output logic               o_dmi_hardreset
);

    dtm_pkg::tap_state_e state_q, state_d;
    dtm_pkg::dtm_dr_u    dr_q, dr_d;
    logic [5:0]          dr_len_q, dr_len_d;     // active shift length
    logic                bypass_q, bypass_d;
    logic                busy_q;                 // target busy, one cycle late
    logic                err_q;                  // target error, one cycle late
    logic [1:0]          stat_q, stat_d;         // sticky dmi status

    // falling-edge registers
    logic [dtm_pkg::DTM_IRLEN-1:0] ir_q, ir_d;
    logic [dtm_pkg::DTM_ABITS-1:0] dmi_addr_q, dmi_addr_d;

    // tap state walk
    always_comb begin
        case (state_q)
            dtm_pkg::TEST_LOGIC_RESET:
                state_d = i_tms ? dtm_pkg::TEST_LOGIC_RESET : dtm_pkg::RUN_TEST_IDLE;
            dtm_pkg::RUN_TEST_IDLE:
                state_d = i_tms ? dtm_pkg::SELECT_DR_SCAN : dtm_pkg::RUN_TEST_IDLE;
            dtm_pkg::SELECT_DR_SCAN:
                state_d = i_tms ? dtm_pkg::SELECT_IR_SCAN : dtm_pkg::CAPTURE_DR;
            dtm_pkg::CAPTURE_DR:
                state_d = i_tms ? dtm_pkg::EXIT1_DR : dtm_pkg::SHIFT_DR;
            dtm_pkg::SHIFT_DR:
                state_d = i_tms ? dtm_pkg::EXIT1_DR : dtm_pkg::SHIFT_DR;
            dtm_pkg::EXIT1_DR:
                state_d = i_tms ? dtm_pkg::UPDATE_DR : dtm_pkg::PAUSE_DR;
            dtm_pkg::PAUSE_DR:
                state_d = i_tms ? dtm_pkg::EXIT2_DR : dtm_pkg::PAUSE_DR;
            dtm_pkg::EXIT2_DR:
                state_d = i_tms ? dtm_pkg::UPDATE_DR : dtm_pkg::SHIFT_DR;
            dtm_pkg::UPDATE_DR:
                state_d = i_tms ? dtm_pkg::SELECT_DR_SCAN : dtm_pkg::RUN_TEST_IDLE;
            dtm_pkg::SELECT_IR_SCAN:
                state_d = i_tms ? dtm_pkg::TEST_LOGIC_RESET : dtm_pkg::CAPTURE_IR;
            dtm_pkg::CAPTURE_IR:
                state_d = i_tms ? dtm_pkg::EXIT1_IR : dtm_pkg::SHIFT_IR;
            dtm_pkg::SHIFT_IR:
                state_d = i_tms ? dtm_pkg::EXIT1_IR : dtm_pkg::SHIFT_IR;
            dtm_pkg::EXIT1_IR:
                state_d = i_tms ? dtm_pkg::UPDATE_IR : dtm_pkg::PAUSE_IR;
            dtm_pkg::PAUSE_IR:
                state_d = i_tms ? dtm_pkg::EXIT2_IR : dtm_pkg::PAUSE_IR;
            dtm_pkg::EXIT2_IR:
                state_d = i_tms ? dtm_pkg::UPDATE_IR : dtm_pkg::SHIFT_IR;
            dtm_pkg::UPDATE_IR:
                state_d = i_tms ? dtm_pkg::SELECT_DR_SCAN : dtm_pkg::RUN_TEST_IDLE;
            default:
                state_d = dtm_pkg::TEST_LOGIC_RESET;
        endcase
    end

    // capture, shift and update actions
    always_comb begin
        logic [dtm_pkg::DTM_DRLEN-1:0] shift_v;

        shift_v         = {1'b0, dr_q[dtm_pkg::DTM_DRLEN-1:1]};
        dr_d            = dr_q;
        dr_len_d        = dr_len_q;
        bypass_d        = bypass_q;
        stat_d          = stat_q;
        ir_d            = ir_q;
        dmi_addr_d      = dmi_addr_q;
        o_dmi_req       = '0;
        o_dmi_hardreset = 1'b0;

        case (state_q)
            dtm_pkg::TEST_LOGIC_RESET: begin
                ir_d = dtm_pkg::IR_IDCODE;
            end
            dtm_pkg::CAPTURE_DR: begin
                case (ir_q)
                    dtm_pkg::IR_IDCODE: begin
                        dr_d     = {{(dtm_pkg::DTM_DRLEN-32){1'b0}}, dtm_pkg::DTM_IDCODE};
                        dr_len_d = 6'd32;
                    end
                    dtm_pkg::IR_DTMCONTROL: begin
                        dr_d              = '0;
                        dr_d.ctrl.version = 4'd1;
                        dr_d.ctrl.abits   = 6'(dtm_pkg::DTM_ABITS);
                        dr_d.ctrl.dmistat = stat_q;
                        dr_len_d          = 6'd32;
                    end
                    dtm_pkg::IR_DBUS: begin
                        dr_d.dbus.addr = dmi_addr_q;     // address of the last scan
                        dr_d.dbus.data = i_dmi_resp.data;
                        dr_d.dbus.op   = stat_q;
                        if (err_q) begin
                            dr_d.dbus.op = dtm_pkg::DMISTAT_FAILED;
                            stat_d       = dtm_pkg::DMISTAT_FAILED;
                        end
                        dr_len_d = 6'(dtm_pkg::DTM_DRLEN);
                    end
                    default: begin                       // bypass and unknown codes
                        dr_d     = '0;
                        dr_d[0]  = bypass_q;
                        dr_len_d = 6'd1;
                    end
                endcase
            end
            dtm_pkg::SHIFT_DR: begin
                if (dr_len_q > 6'd1) begin
                    shift_v[dr_len_q - 6'd1] = i_tdi;    // tdi enters at top of length
                    dr_d = shift_v;
                end else begin
                    dr_d[0] = i_tdi;
                end
            end
            dtm_pkg::UPDATE_DR: begin
                if (ir_q == dtm_pkg::IR_DTMCONTROL) begin
                    o_dmi_hardreset = dr_q.ctrl.dmihardreset;
                    if (dr_q.ctrl.dmireset) begin
                        stat_d = dtm_pkg::DMISTAT_SUCCESS;
                    end
                end else if (ir_q == dtm_pkg::IR_DBUS) begin
                    dmi_addr_d      = dr_q.dbus.addr;
                    o_dmi_req.write = dr_q.dbus.op[1];
                    o_dmi_req.addr  = dr_q.dbus.addr;
                    o_dmi_req.data  = dr_q.dbus.data;
                    // sticky failure or busy drops the access
                    if (stat_q == dtm_pkg::DMISTAT_SUCCESS) begin
                        if (busy_q) begin
                            stat_d = dtm_pkg::DMISTAT_BUSY;
                        end else begin
                            o_dmi_req.valid = |dr_q.dbus.op;
                        end
                    end
                end else if (ir_q != dtm_pkg::IR_IDCODE) begin
                    bypass_d = dr_q[0];
                end
            end
            dtm_pkg::CAPTURE_IR: begin
                dr_d = '0;
                dr_d[dtm_pkg::DTM_IRLEN-1:0] = {ir_q[dtm_pkg::DTM_IRLEN-1:2], 2'b01};
            end
            dtm_pkg::SHIFT_IR: begin
                dr_d[dtm_pkg::DTM_IRLEN-1:0] = {i_tdi, dr_q[dtm_pkg::DTM_IRLEN-1:1]};
            end
            dtm_pkg::UPDATE_IR: begin
                ir_d = dr_q[dtm_pkg::DTM_IRLEN-1:0];
            end
            default: ;                                   // select, exit and pause hold
        endcase
    end

    always_ff @(posedge i_tck, posedge i_trst) begin
        if (i_trst) begin
            state_q  <= dtm_pkg::TEST_LOGIC_RESET;
            dr_q     <= {{(dtm_pkg::DTM_DRLEN-32){1'b0}}, dtm_pkg::DTM_IDCODE};
            dr_len_q <= 6'd32;
            bypass_q <= 1'b0;
            busy_q   <= 1'b0;
            err_q    <= 1'b0;
            stat_q   <= dtm_pkg::DMISTAT_SUCCESS;
        end else begin
            state_q  <= state_d;
            dr_q     <= dr_d;
            dr_len_q <= dr_len_d;
            bypass_q <= bypass_d;
            busy_q   <= i_dmi_resp.busy;
            err_q    <= i_dmi_resp.error;
            stat_q   <= stat_d;
        end
    end

    // ir and dmi address settle mid-cycle after the update state
    always_ff @(negedge i_tck, posedge i_trst) begin
        if (i_trst) begin
            ir_q       <= dtm_pkg::IR_IDCODE;
            dmi_addr_q <= '0;
        end else begin
            ir_q       <= ir_d;
            dmi_addr_q <= dmi_addr_d;
        end
    end

    assign o_tdo = dr_q[0];                              // lsb first

endmodule

// ==== hdl/dmi_regfile.sv ====
// dmi register target
//   16 x 32-bit register bank
//   one request at a time, then busy for a fixed count
//   error flag for addresses past the bank
//   bank clear on dtm hard reset

`timescale 1ns/10ps

module dmi_regfile (
    input  logic               i_tck,
    input  logic               i_trst,
    input  dtm_pkg::dmi_req_t  i_dmi_req,
    input  logic               i_hardreset,
    output dtm_pkg::dmi_resp_t o_dmi_resp
);

    logic [31:0] regs_q [dtm_pkg::DMI_REG_COUNT];

    // down-counter, nonzero while busy
    logic [$clog2(dtm_pkg::DMI_BUSY_CYCLES+1)-1:0] busy_cnt_q;

    logic [31:0] rdata_q;                                // last read value
    logic        err_q;

    logic                                      addr_bad;
    logic [$clog2(dtm_pkg::DMI_REG_COUNT)-1:0] idx;
    logic                                      wr_en;

    assign addr_bad = i_dmi_req.addr >= dtm_pkg::DTM_ABITS'(dtm_pkg::DMI_REG_COUNT);
    assign idx      = i_dmi_req.addr[$clog2(dtm_pkg::DMI_REG_COUNT)-1:0];
    assign wr_en    = i_dmi_req.valid & i_dmi_req.write & ~addr_bad;

    // register bank
    always_ff @(posedge i_tck) begin
        if (i_hardreset) begin
            for (int i = 0; i < dtm_pkg::DMI_REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[idx] <= i_dmi_req.data;
        end
    end

    // busy countdown, reloaded on every accepted request
    always_ff @(posedge i_tck, posedge i_trst) begin
        if (i_trst) begin
            busy_cnt_q <= '0;
        end else if (i_dmi_req.valid) begin
            busy_cnt_q <= ($clog2(dtm_pkg::DMI_BUSY_CYCLES+1))'(dtm_pkg::DMI_BUSY_CYCLES);
        end else if (busy_cnt_q != '0) begin
            busy_cnt_q <= busy_cnt_q - 1'b1;
        end
    end

    // error level follows the address of the last request
    always_ff @(posedge i_tck, posedge i_trst) begin
        if (i_trst) begin
            err_q <= 1'b0;
        end else if (i_dmi_req.valid) begin
            err_q <= addr_bad;
        end
    end

    // read data
    always_ff @(posedge i_tck, posedge i_trst) begin
        if (i_trst) begin
            rdata_q <= '0;
        end else if (i_dmi_req.valid) begin
            if (addr_bad) begin
                rdata_q <= '0;                           // nothing to return
            end else if (!i_dmi_req.write) begin
                rdata_q <= regs_q[idx];
            end
        end
    end

    always_comb begin
        o_dmi_resp.data  = rdata_q;
        o_dmi_resp.busy  = busy_cnt_q != '0;
        o_dmi_resp.error = err_q;
    end

endmodule

// ==== hdl/dbg_top.sv ====
// debug top level
//   jtag dtm driving the dmi
//   dmi register target
//   hard-reset pulse brought out for monitoring

`timescale 1ns/10ps

module dbg_top (
    input  logic i_tck,
    input  logic i_trst,
    input  logic i_tms,
    input  logic i_tdi,
    output logic o_tdo,
    output logic o_dmi_hardreset
);

    dtm_pkg::dmi_req_t  dmi_req;                         // dtm to target
    dtm_pkg::dmi_resp_t dmi_resp;                        // target to dtm
    logic               dmi_hardreset;

    jtag_dtm jtag_dtm_i (
        .i_tck           (i_tck),
        .i_trst          (i_trst),
        .i_tms           (i_tms),
        .i_tdi           (i_tdi),
        .i_dmi_resp      (dmi_resp),
        .o_tdo           (o_tdo),
        .o_dmi_req       (dmi_req),
        .o_dmi_hardreset (dmi_hardreset)
    );

    dmi_regfile dmi_regfile_i (
        .i_tck       (i_tck),
        .i_trst      (i_trst),
        .i_dmi_req   (dmi_req),
        .i_hardreset (dmi_hardreset),
        .o_dmi_resp  (dmi_resp)
    );

    assign o_dmi_hardreset = dmi_hardreset;

endmodule

// ==== tests/tb_dbg_top.sv ====
// testbench for the jtag debug transport and dmi target
//   clock, trst and jtag bit-level scan tasks
//   table of ir/dr scans with expected captures applied in a loop
//   compare task, hard-reset pulse monitor, watchdog

`timescale 1ns/10ps

module tb_dbg_top;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 3;
    localparam int IRLEN        = dtm_pkg::DTM_IRLEN;
    localparam int DRLEN        = dtm_pkg::DTM_DRLEN;
    localparam int BUSY         = dtm_pkg::DMI_BUSY_CYCLES;

    localparam logic [1:0] OP_READ  = 2'd1;
    localparam logic [1:0] OP_WRITE = 2'd2;

    localparam logic [DRLEN-1:0] MASK_OP        = 41'h3;            // dbus status only
    localparam logic [DRLEN-1:0] MASK_CTRL      = 41'hfff;
    localparam logic [DRLEN-1:0] MASK_32        = 41'hffff_ffff;
    localparam logic [DRLEN-1:0] MASK_ALL       = '1;
    localparam logic [DRLEN-1:0] CTRL_DMIRESET  = 41'h1_0000;       // bit 16
    localparam logic [DRLEN-1:0] CTRL_HARDRESET = 41'h2_0000;       // bit 17

    typedef struct packed {
        logic             trst_first;                   // pulse trst before the row
        logic [IRLEN-1:0] ir;
        logic [5:0]       len;
        logic [DRLEN-1:0] din;
        logic [DRLEN-1:0] expected;
        logic [DRLEN-1:0] mask;
        logic [7:0]       idle;
    } scan_row_t;

    logic tck;
    logic trst;
    logic tms;
    logic tdi;
    logic tdo;
    logic dmi_hardreset;

    scan_row_t                     table_q[$];
    int                            errors;
    int                            hardreset_pulses;
    logic [31:0]                   wdata [4];
    logic [dtm_pkg::DTM_ABITS-1:0] test_addr [4] = '{7'd0, 7'd3, 7'd9, 7'd15};

    dbg_top dbg_top_i (
        .i_tck           (tck),
        .i_trst          (trst),
        .i_tms           (tms),
        .i_tdi           (tdi),
        .o_tdo           (tdo),
        .o_dmi_hardreset (dmi_hardreset)
    );

    always #(CLK_PERIOD / 2) tck = ~tck;

    // counts high cycles of the hard-reset pulse at mid-cycle
    always @(negedge tck) begin
        if (dmi_hardreset === 1'b1) begin
            hardreset_pulses++;
        end
    end

    task automatic check_value(input string what, input logic [DRLEN-1:0] actual,
                               input logic [DRLEN-1:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %t %s: got %h, expected %h", $realtime, what, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // one tck cycle with tdo taken before the new tms/tdi
    task automatic clock_bit(input logic tms_v, input logic tdi_v, output logic tdo_v);
        @(negedge tck);
        tdo_v = tdo;
        tms   = tms_v;
        tdi   = tdi_v;
    endtask

    task automatic go_to_reset();
        logic unused;
        repeat (5) clock_bit(1'b1, 1'b0, unused);       // any state to test-logic-reset
        clock_bit(1'b0, 1'b0, unused);
    endtask

    task automatic apply_reset();
        trst = 1'b1;
        tms  = 1'b1;
        repeat (RESET_CYCLES) @(negedge tck);
        trst = 1'b0;
        go_to_reset();
    endtask

    task automatic idle_cycles(input int k);
        logic unused;
        repeat (k) clock_bit(1'b0, 1'b0, unused);
    endtask

    // ir or dr scan from run-test/idle back to run-test/idle
    task automatic shift_scan(input logic is_ir, input int len, input logic [DRLEN-1:0] din,
                              output logic [DRLEN-1:0] dout);
        logic bit_out;
        dout = '0;
        clock_bit(1'b1, 1'b0, bit_out);                 // select-dr
        if (is_ir) begin
            clock_bit(1'b1, 1'b0, bit_out);
        end
        clock_bit(1'b0, 1'b0, bit_out);                 // capture
        clock_bit(1'b0, 1'b0, bit_out);
        for (int i = 0; i < len; i++) begin
            clock_bit(i == len - 1, din[i], bit_out);   // last bit leaves via exit1
            dout[i] = bit_out;
        end
        clock_bit(1'b1, 1'b0, bit_out);                 // update
        clock_bit(1'b0, 1'b0, bit_out);
    endtask

    function automatic logic [DRLEN-1:0] dbus_word(input logic [dtm_pkg::DTM_ABITS-1:0] addr,
                                                   input logic [31:0] data, input logic [1:0] op);
        return {addr, data, op};
    endfunction

    function automatic logic [DRLEN-1:0] ctrl_word(input logic [1:0] stat);
        logic [DRLEN-1:0] w;
        w        = '0;
        w[3:0]   = 4'd1;                                // version
        w[9:4]   = 6'(dtm_pkg::DTM_ABITS);
        w[11:10] = stat;
        return w;
    endfunction

    function automatic void add_row(input logic trst_first, input logic [IRLEN-1:0] ir,
                                    input int len, input logic [DRLEN-1:0] din,
                                    input logic [DRLEN-1:0] expected,
                                    input logic [DRLEN-1:0] mask, input int idle);
        scan_row_t r;
        r.trst_first = trst_first;
        r.ir         = ir;
        r.len        = 6'(len);
        r.din        = din;
        r.expected   = expected;
        r.mask       = mask;
        r.idle       = 8'(idle);
        table_q.push_back(r);
    endfunction

    task automatic build_table();
        logic [31:0] rnd;
        rnd = $urandom;                                 // idcode read without a prior ir scan
        add_row(1'b0, dtm_pkg::IR_IDCODE, 32, DRLEN'(rnd), DRLEN'(dtm_pkg::DTM_IDCODE),
                MASK_32, 2);
        rnd = $urandom;
        add_row(1'b0, dtm_pkg::IR_BYPASS, 32, DRLEN'(rnd), DRLEN'({rnd[30:0], 1'b0}), MASK_32, 2);
        add_row(1'b0, dtm_pkg::IR_DTMCONTROL, 32, '0, ctrl_word(dtm_pkg::DMISTAT_SUCCESS),
                MASK_CTRL, 2);
        for (int j = 0; j < 4; j++) begin
            wdata[j] = $urandom;
            add_row(1'b0, dtm_pkg::IR_DBUS, DRLEN, dbus_word(test_addr[j], wdata[j], OP_WRITE),
                    '0, MASK_OP, BUSY);
        end
        for (int j = 0; j < 4; j++) begin
            add_row(1'b0, dtm_pkg::IR_DBUS, DRLEN, dbus_word(test_addr[j], 32'd0, OP_READ),
                    '0, MASK_OP, BUSY);
            add_row(1'b0, dtm_pkg::IR_DBUS, DRLEN, '0,
                    dbus_word(test_addr[j], wdata[j], dtm_pkg::DMISTAT_SUCCESS), MASK_ALL, 2);
        end
        // address past the bank and then a write that must be dropped
        rnd = $urandom;
        add_row(1'b0, dtm_pkg::IR_DBUS, DRLEN, dbus_word(7'd20, rnd, OP_WRITE), '0, MASK_OP, BUSY);
        add_row(1'b0, dtm_pkg::IR_DBUS, DRLEN, dbus_word(test_addr[0], ~wdata[0], OP_WRITE),
                dbus_word(7'd20, 32'd0, dtm_pkg::DMISTAT_FAILED), MASK_ALL, 8);
        add_row(1'b0, dtm_pkg::IR_DTMCONTROL, 32, CTRL_DMIRESET,
                ctrl_word(dtm_pkg::DMISTAT_FAILED), MASK_CTRL, 2);
        add_row(1'b0, dtm_pkg::IR_DTMCONTROL, 32, '0, ctrl_word(dtm_pkg::DMISTAT_SUCCESS),
                MASK_CTRL, 2);
        // trst clears the error level while the bank keeps its data
        add_row(1'b1, dtm_pkg::IR_DBUS, DRLEN, dbus_word(test_addr[0], 32'd0, OP_READ),
                '0, MASK_OP, BUSY);
        add_row(1'b0, dtm_pkg::IR_DBUS, DRLEN, '0,
                dbus_word(test_addr[0], wdata[0], dtm_pkg::DMISTAT_SUCCESS), MASK_ALL, 2);
        // back-to-back scans hit busy
        rnd = $urandom;
        add_row(1'b0, dtm_pkg::IR_DBUS, DRLEN, dbus_word(test_addr[1], rnd, OP_WRITE),
                '0, MASK_OP, 0);
        add_row(1'b0, dtm_pkg::IR_DBUS, DRLEN, dbus_word(test_addr[2], ~rnd, OP_WRITE),
                '0, MASK_OP, 2);
        add_row(1'b0, dtm_pkg::IR_DBUS, DRLEN, '0, DRLEN'(dtm_pkg::DMISTAT_BUSY), MASK_OP, 2);
        add_row(1'b0, dtm_pkg::IR_DTMCONTROL, 32, CTRL_DMIRESET,
                ctrl_word(dtm_pkg::DMISTAT_BUSY), MASK_CTRL, 2);
        add_row(1'b0, dtm_pkg::IR_DTMCONTROL, 32, CTRL_HARDRESET,
                ctrl_word(dtm_pkg::DMISTAT_SUCCESS), MASK_CTRL, 2);
        for (int j = 1; j < 4; j += 2) begin
            add_row(1'b0, dtm_pkg::IR_DBUS, DRLEN, dbus_word(test_addr[j], 32'd0, OP_READ),
                    '0, MASK_OP, BUSY);
            add_row(1'b0, dtm_pkg::IR_DBUS, DRLEN, '0,
                    dbus_word(test_addr[j], 32'd0, dtm_pkg::DMISTAT_SUCCESS), MASK_ALL, 2);
        end
    endtask

    // tck cycles of the whole table with an ir scan counted on every row
    function automatic longint run_cycles();
        longint total;
        total = RESET_CYCLES + 6;
        foreach (table_q[i]) begin
            total += table_q[i].trst_first ? RESET_CYCLES + 6 : 0;
            total += IRLEN + 6 + int'(table_q[i].len) + 5 + int'(table_q[i].idle);
        end
        return total + 4;
    endfunction

    task automatic watchdog(input longint limit_ns);
        #(limit_ns);
        $display("watchdog expired after %0d ns with the scan table unfinished", limit_ns);
        $display("Test failed");
        $fatal(1);
    endtask

    initial begin
        scan_row_t        row;
        logic [IRLEN-1:0] cur_ir;
        logic [DRLEN-1:0] cap;
        longint           limit_ns;

        tck  = 1'b0;
        trst = 1'b1;
        tms  = 1'b1;
        tdi  = 1'b0;
        errors = 0;
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(32'h3a0681c8));
        build_table();
        limit_ns = 2 * run_cycles() * CLK_PERIOD;
        fork
            watchdog(limit_ns);
        join_none

        apply_reset();
        cur_ir = dtm_pkg::IR_IDCODE;
        foreach (table_q[i]) begin
            row = table_q[i];
            if (row.trst_first) begin
                apply_reset();
                cur_ir = dtm_pkg::IR_IDCODE;
            end
            if (row.ir != cur_ir) begin
                shift_scan(1'b1, IRLEN, DRLEN'(row.ir), cap);
                check_value($sformatf("row %0d ir capture", i), cap & 41'h3, 41'h1);
                cur_ir = row.ir;
            end
            shift_scan(1'b0, int'(row.len), row.din, cap);
            check_value($sformatf("row %0d dr capture", i), cap & row.mask,
                        row.expected & row.mask);
            idle_cycles(int'(row.idle));
        end
        idle_cycles(4);
        check_value("hard-reset pulse cycles", DRLEN'(hardreset_pulses), DRLEN'(1));

        if (errors == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

// ==== all.f ====
hdl/dtm_pkg.sv
hdl/jtag_dtm.sv
hdl/dmi_regfile.sv
hdl/dbg_top.sv
tests/tb_dbg_top.sv

// ==== Bender.yml ====
package:
  name: dbg_dtm

sources:
  # design
  - files:
      - hdl/dtm_pkg.sv
      - hdl/jtag_dtm.sv
      - hdl/dmi_regfile.sv
      - hdl/dbg_top.sv

  # testbench
  - target: test
    files:
      - tests/tb_dbg_top.sv
